// File: src/snakeGamePkg.sv
`default_nettype none

package snakeGamePkg;

    // pixel and game quantities
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;
    typedef logic [2:0] colour_t;
    typedef logic [3:0] score_t;

    // opposite headings differ only in bit 0
    typedef enum logic [1:0] {
        headUp    = 2'b00,
        headDown  = 2'b01,
        headLeft  = 2'b10,
        headRight = 2'b11
    } heading_t;

    typedef enum logic [3:0] {
        drawInitApple,
        drawInitSnake,
        waitStart,
        waitTick,
        eraseSnake,
        step,
        checkApple,
        drawApple,
        drawSnake,
        drawGameOver,
        gameOver
    } gameState_t;

    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    localparam int AppleSize = 4;

    localparam colour_t BackgroundColour = 3'b000;
    localparam colour_t AppleColour = 3'b100;
    localparam colour_t GameOverColour = 3'b101;

    // apple positions, visited in order and wrapping
    localparam int AppleCount = 6;
    localparam xCoord_t AppleX [AppleCount] = '{8'd30, 8'd10, 8'd70, 8'd60, 8'd20, 8'd50};
    localparam yCoord_t AppleY [AppleCount] = '{7'd30, 7'd20, 7'd90, 7'd100, 7'd80, 7'd10};

    // head start, body stacked below it
    localparam int StartX = 80;
    localparam int StartY = 60;

endpackage

`default_nettype wire

// File: src/moveControl.sv
`default_nettype none
`timescale 1ns/1ps

module moveControl (
    input  wire logic             Clock,
    input  wire logic             reset,
    input  wire logic [3:0]       keyN,
    output snakeGamePkg::heading_t heading,
    output logic                  started
);
    import snakeGamePkg::*;

    heading_t pressHeading;
    logic anyPress;
    logic reversal;

    // right, down, up, left in falling priority
    always_comb
    begin
        pressHeading = heading;
        if (!keyN[0])
            pressHeading = headRight;
        else if (!keyN[1])
            pressHeading = headDown;
        else if (!keyN[2])
            pressHeading = headUp;
        else if (!keyN[3])
            pressHeading = headLeft;
    end

    assign anyPress = (keyN != 4'b1111);

    // opposite pair when only bit 0 differs
    assign reversal = ((2'(pressHeading) ^ 2'(heading)) == 2'b01);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= headUp;
            started <= 1'b0;
        end
        else if (anyPress)
        begin
            started <= 1'b1;
            if (!reversal)
                heading <= pressHeading;
        end
    end

endmodule

`default_nettype wire

// File: src/snakeBody.sv
`default_nettype none
`timescale 1ns/1ps

module snakeBody #(
    parameter int SegSize = 10,
    parameter int MaxLength = 6
) (
    input  wire logic                   Clock,
    input  wire logic                   reset,
    input  wire logic                   stepEnable,
    input  wire snakeGamePkg::heading_t heading,
    input  wire logic [2:0]             segIndex,
    output snakeGamePkg::xCoord_t       segX,
    output snakeGamePkg::yCoord_t       segY,
    output snakeGamePkg::xCoord_t       headX,
    output snakeGamePkg::yCoord_t       headY,
    output logic                        crashed
);
    import snakeGamePkg::*;

    // index 0 is the head
    xCoord_t segXr [MaxLength];
    yCoord_t segYr [MaxLength];

    int nextX;
    int nextY;
    logic offScreen;
    logic selfHit;

    assign headX = segXr[0];
    assign headY = segYr[0];
    assign segX = segXr[segIndex];
    assign segY = segYr[segIndex];

    // candidate head, signed so the left and top edges show up as negative
    always_comb
    begin
        nextX = int'(segXr[0]);
        nextY = int'(segYr[0]);
        case (heading)
            headUp:   nextY = nextY - SegSize;
            headDown: nextY = nextY + SegSize;
            headLeft: nextX = nextX - SegSize;
            default:  nextX = nextX + SegSize;
        endcase
    end

    assign offScreen = (nextX < 0) || (nextY < 0) ||
                       (nextX + SegSize > ScreenWidth) ||
                       (nextY + SegSize > ScreenHeight);

    // whole-segment moves, so equality is enough
    // tail segment moves away this step and is skipped
    always_comb
    begin
        selfHit = 1'b0;
        for (int i = 1; i <= MaxLength - 2; i++)
        begin
            if (segXr[i] == xCoord_t'(nextX) && segYr[i] == yCoord_t'(nextY))
                selfHit = 1'b1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            crashed <= 1'b0;
            for (int i = 0; i < MaxLength; i++)
            begin
                segXr[i] <= xCoord_t'(StartX);
                segYr[i] <= yCoord_t'(StartY + i * SegSize);
            end
        end
        else if (stepEnable && !crashed)
        begin
            if (offScreen || selfHit)
                crashed <= 1'b1;
            else
            begin
                for (int i = MaxLength - 1; i > 0; i--)
                begin
                    segXr[i] <= segXr[i - 1];
                    segYr[i] <= segYr[i - 1];
                end
                segXr[0] <= xCoord_t'(nextX);
                segYr[0] <= yCoord_t'(nextY);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/appleTracker.sv
`default_nettype none
`timescale 1ns/1ps

module appleTracker #(
    parameter int SegSize = 10
) (
    input  wire logic                  Clock,
    input  wire logic                  reset,
    input  wire logic                  appleCheck,
    input  wire snakeGamePkg::xCoord_t headX,
    input  wire snakeGamePkg::yCoord_t headY,
    output snakeGamePkg::xCoord_t      appleX,
    output snakeGamePkg::yCoord_t      appleY,
    output snakeGamePkg::score_t       score
);
    import snakeGamePkg::*;

    logic [2:0] appleIndex;
    logic overlapX;
    logic overlapY;
    logic eat;

    assign appleX = AppleX[appleIndex];
    assign appleY = AppleY[appleIndex];

    // head square against apple square, per axis
    assign overlapX = (int'(headX) < int'(appleX) + AppleSize) &&
                      (int'(headX) + SegSize > int'(appleX));
    assign overlapY = (int'(headY) < int'(appleY) + AppleSize) &&
                      (int'(headY) + SegSize > int'(appleY));

    assign eat = appleCheck && overlapX && overlapY;

    always_ff @(posedge Clock)
    begin
        if (reset)
            appleIndex <= 3'd0;
        else if (eat)
        begin
            if (appleIndex == 3'(AppleCount - 1))
                appleIndex <= 3'd0;
            else
                appleIndex <= appleIndex + 3'd1;
        end
    end

    // single decimal digit, holds at 9
    always_ff @(posedge Clock)
    begin
        if (reset)
            score <= '0;
        else if (eat && score != 4'd9)
            score <= score + 4'd1;
    end

endmodule

`default_nettype wire

// File: src/scoreSegments.sv
`default_nettype none
`timescale 1ns/1ps

module scoreSegments (
    input  wire snakeGamePkg::score_t score,
    output logic [6:0]                scoreDigit
);

    // active low, bit 0 top, bit 6 middle
    always_comb
    begin
        case (score)
            4'd0:    scoreDigit = 7'b1000000;
            4'd1:    scoreDigit = 7'b1111001;
            4'd2:    scoreDigit = 7'b0100100;
            4'd3:    scoreDigit = 7'b0110000;
            4'd4:    scoreDigit = 7'b0011001;
            4'd5:    scoreDigit = 7'b0010010;
            4'd6:    scoreDigit = 7'b0000010;
            4'd7:    scoreDigit = 7'b1111000;
            4'd8:    scoreDigit = 7'b0000000;
            4'd9:    scoreDigit = 7'b0011000;
            // blank outside 0-9
            default: scoreDigit = 7'b1111111;
        endcase
    end

endmodule

`default_nettype wire

// File: src/rectScanner.sv
`default_nettype none
`timescale 1ns/1ps

module rectScanner (
    input  wire logic                  Clock,
    input  wire logic                  reset,
    input  wire logic                  scanStart,
    input  wire snakeGamePkg::xCoord_t originX,
    input  wire snakeGamePkg::yCoord_t originY,
    input  wire logic [3:0]            areaSize,
    input  wire logic                  scanAdvance,
    output snakeGamePkg::xCoord_t      scanX,
    output snakeGamePkg::yCoord_t      scanY,
    output logic                       scanLast
);

    logic [3:0] colOffset;
    logic [3:0] rowOffset;
    logic rowEnd;

    assign rowEnd = (colOffset == areaSize - 4'd1);
    assign scanLast = rowEnd && (rowOffset == areaSize - 4'd1);

    assign scanX = originX + colOffset;
    assign scanY = originY + rowOffset;

    // across the row, then down; wraps to the corner after the last pixel
    always_ff @(posedge Clock)
    begin
        if (reset || scanStart)
        begin
            colOffset <= 4'd0;
            rowOffset <= 4'd0;
        end
        else if (scanAdvance)
        begin
            if (rowEnd)
            begin
                colOffset <= 4'd0;
                rowOffset <= scanLast ? 4'd0 : rowOffset + 4'd1;
            end
            else
                colOffset <= colOffset + 4'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/drawSequencer.sv
`default_nettype none
`timescale 1ns/1ps

module drawSequencer #(
    parameter int SegSize = 10,
    parameter int MaxLength = 6,
    parameter int FrameCycles = 1000000,
    parameter int CreditDepth = 4
) (
    input  wire logic                  Clock,
    input  wire logic                  reset,
    input  wire logic                  started,
    input  wire logic                  crashed,
    input  wire snakeGamePkg::xCoord_t headX,
    input  wire snakeGamePkg::yCoord_t headY,
    input  wire snakeGamePkg::xCoord_t segX,
    input  wire snakeGamePkg::yCoord_t segY,
    input  wire snakeGamePkg::xCoord_t appleX,
    input  wire snakeGamePkg::yCoord_t appleY,
    input  wire snakeGamePkg::colour_t snakeColour,
    input  wire logic                  creditReturn,
    output logic [2:0]                 segIndex,
    output logic                       stepEnable,
    output logic                       appleCheck,
    output logic                       pixelValid,
    output snakeGamePkg::xCoord_t      pixelX,
    output snakeGamePkg::yCoord_t      pixelY,
    output snakeGamePkg::colour_t      pixelColour
);
    import snakeGamePkg::*;

    localparam int CountBits = $clog2(CreditDepth + 1);
    localparam int TickBits = $clog2(FrameCycles);

    gameState_t state;
    gameState_t nextState;
    logic firstCycle;
    logic [CountBits-1:0] creditCount;
    logic [TickBits-1:0] tickCount;
    logic running;
    logic frameTick;

    logic drawing;
    logic segmentArea;
    logic lastSeg;
    logic areaDone;
    logic scanStart;
    logic scanLast;
    xCoord_t originX;
    yCoord_t originY;
    logic [3:0] areaSize;

    // area, size and colour for the current state
    always_comb
    begin
        drawing = 1'b0;
        segmentArea = 1'b0;
        originX = segX;
        originY = segY;
        areaSize = 4'(SegSize);
        pixelColour = snakeColour;
        case (state)
            drawInitApple, drawApple:
            begin
                drawing = 1'b1;
                originX = appleX;
                originY = appleY;
                areaSize = 4'(AppleSize);
                pixelColour = AppleColour;
            end
            drawInitSnake, drawSnake:
            begin
                drawing = 1'b1;
                segmentArea = 1'b1;
            end
            eraseSnake:
            begin
                drawing = 1'b1;
                segmentArea = 1'b1;
                pixelColour = BackgroundColour;
            end
            drawGameOver:
            begin
                drawing = 1'b1;
                originX = headX;
                originY = headY;
                pixelColour = GameOverColour;
            end
            default:
            begin
            end
        endcase
    end

    // first cycle of each drawing state rewinds the scanner
    assign scanStart = drawing && firstCycle;
    assign pixelValid = drawing && !firstCycle && (creditCount != '0);
    assign areaDone = pixelValid && scanLast;
    assign lastSeg = (segIndex == 3'(MaxLength - 1));

    assign stepEnable = (state == step);
    assign appleCheck = (state == checkApple) && !crashed;

    rectScanner rectScanner_i (
        .Clock       (Clock),
        .reset       (reset),
        .scanStart   (scanStart),
        .originX     (originX),
        .originY     (originY),
        .areaSize    (areaSize),
        .scanAdvance (pixelValid),
        .scanX       (pixelX),
        .scanY       (pixelY),
        .scanLast    (scanLast)
    );

    always_comb
    begin
        nextState = state;
        case (state)
            drawInitApple: if (areaDone) nextState = drawInitSnake;
            drawInitSnake: if (areaDone && lastSeg) nextState = waitStart;
            waitStart:     if (started) nextState = waitTick;
            waitTick:      if (frameTick) nextState = eraseSnake;
            eraseSnake:    if (areaDone && lastSeg) nextState = step;
            step:          nextState = checkApple;
            checkApple:    nextState = crashed ? drawGameOver : drawApple;
            drawApple:     if (areaDone) nextState = drawSnake;
            drawSnake:     if (areaDone && lastSeg) nextState = waitTick;
            drawGameOver:  if (areaDone) nextState = gameOver;
            default:       nextState = gameOver;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= drawInitApple;
            firstCycle <= 1'b1;
            segIndex <= 3'd0;
        end
        else
        begin
            state <= nextState;
            firstCycle <= (nextState != state);
            if (segmentArea && areaDone)
                segIndex <= lastSeg ? 3'd0 : segIndex + 3'd1;
        end
    end

    // one credit per write spent, one per return gained
    always_ff @(posedge Clock)
    begin
        if (reset)
            creditCount <= CountBits'(CreditDepth);
        else
            creditCount <= creditCount + CountBits'(creditReturn) - CountBits'(pixelValid);
    end

    // frame divider, only while the game runs
    assign running = started && !crashed;
    assign frameTick = running && (tickCount == TickBits'(FrameCycles - 1));

    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else if (running)
            tickCount <= frameTick ? '0 : tickCount + 1'b1;
    end

endmodule

`default_nettype wire

// File: src/snakeGame.sv
`default_nettype none
`timescale 1ns/1ps

module snakeGame #(
    parameter int SegSize = 10,
    parameter int MaxLength = 6,
    parameter int FrameCycles = 1000000,
    parameter int CreditDepth = 4
) (
    input  wire logic                  Clock,
    input  wire logic                  reset,
    input  wire logic [3:0]            keyN,
    input  wire snakeGamePkg::colour_t snakeColour,
    input  wire logic                  creditReturn,
    output logic                       pixelValid,
    output snakeGamePkg::xCoord_t      pixelX,
    output snakeGamePkg::yCoord_t      pixelY,
    output snakeGamePkg::colour_t      pixelColour,
    output logic [6:0]                 scoreDigit
);
    import snakeGamePkg::*;

    heading_t heading;
    logic started;
    logic stepEnable;
    logic appleCheck;
    logic crashed;
    logic [2:0] segIndex;
    xCoord_t segX;
    yCoord_t segY;
    xCoord_t headX;
    yCoord_t headY;
    xCoord_t appleX;
    yCoord_t appleY;
    score_t score;

    moveControl moveControl_i (
        .Clock   (Clock),
        .reset   (reset),
        .keyN    (keyN),
        .heading (heading),
        .started (started)
    );

    snakeBody #(
        .SegSize   (SegSize),
        .MaxLength (MaxLength)
    ) snakeBody_i (
        .Clock      (Clock),
        .reset      (reset),
        .stepEnable (stepEnable),
        .heading    (heading),
        .segIndex   (segIndex),
        .segX       (segX),
        .segY       (segY),
        .headX      (headX),
        .headY      (headY),
        .crashed    (crashed)
    );

    appleTracker #(
        .SegSize (SegSize)
    ) appleTracker_i (
        .Clock      (Clock),
        .reset      (reset),
        .appleCheck (appleCheck),
        .headX      (headX),
        .headY      (headY),
        .appleX     (appleX),
        .appleY     (appleY),
        .score      (score)
    );

    scoreSegments scoreSegments_i (
        .score      (score),
        .scoreDigit (scoreDigit)
    );

    drawSequencer #(
        .SegSize     (SegSize),
        .MaxLength   (MaxLength),
        .FrameCycles (FrameCycles),
        .CreditDepth (CreditDepth)
    ) drawSequencer_i (
        .Clock        (Clock),
        .reset        (reset),
        .started      (started),
        .crashed      (crashed),
        .headX        (headX),
        .headY        (headY),
        .segX         (segX),
        .segY         (segY),
        .appleX       (appleX),
        .appleY       (appleY),
        .snakeColour  (snakeColour),
        .creditReturn (creditReturn),
        .segIndex     (segIndex),
        .stepEnable   (stepEnable),
        .appleCheck   (appleCheck),
        .pixelValid   (pixelValid),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .pixelColour  (pixelColour)
    );

endmodule

`default_nettype wire

// File: tests/snakeGameTb.sv
`default_nettype none
`timescale 1ns/1ps

module snakeGameTb;
    import snakeGamePkg::*;

    localparam int SegSize = 10;
    localparam int MaxLength = 6;
    localparam int FrameCycles = 2000;
    localparam int CreditDepth = 4;
    localparam colour_t SnakeColour = 3'b010;

    // one frame is an erase, an apple and a redraw
    localparam int FramePixels = 2 * MaxLength * SegSize * SegSize + AppleSize * AppleSize;
    localparam int WatchdogCycles = 40 * FrameCycles + 8 * 16 * FramePixels;

    // digit d lights a segment when bit d of its mask is set
    localparam logic [9:0] SegMask [7] = '{
        10'b1111101101, 10'b1110011111, 10'b1111111011, 10'b1101101101,
        10'b0101000101, 10'b1101110001, 10'b1101111100
    };

    logic Clock;
    logic reset;
    logic [3:0] keyN;
    colour_t snakeColour;
    logic creditReturn;
    logic pixelValid;
    xCoord_t pixelX;
    yCoord_t pixelY;
    colour_t pixelColour;
    logic [6:0] scoreDigit;

    // expected writes as {x, y, colour}
    logic [17:0] expectedPixels [$];
    logic [17:0] expectedPixel;
    logic [17:0] lastWrite = '0;
    string testName = "reset";
    int outstanding = 0;
    logic [15:0] lfsrState = 16'd44;

    // reference model of the game
    int modelX [MaxLength];
    int modelY [MaxLength];
    heading_t modelHeading;
    int modelAppleIdx;
    int modelScore;
    logic modelCrashed;

    snakeGame #(
        .SegSize     (SegSize),
        .MaxLength   (MaxLength),
        .FrameCycles (FrameCycles),
        .CreditDepth (CreditDepth)
    ) snakeGame_i (
        .Clock        (Clock),
        .reset        (reset),
        .keyN         (keyN),
        .snakeColour  (snakeColour),
        .creditReturn (creditReturn),
        .pixelValid   (pixelValid),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .pixelColour  (pixelColour),
        .scoreDigit   (scoreDigit)
    );

    initial
    begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    task automatic stopRun();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportValue(input string test, input string expected, input string actual);
        $display("** Error [%s]: expected %s, actual %s", test, expected, actual);
        stopRun();
    endtask

    task automatic failWithMessage(input string why);
        $display("Error: %s", why);
        stopRun();
    endtask

    function automatic string describePixel(input logic [17:0] p);
        return $sformatf("(%0d,%0d) colour %b", p[17:10], p[9:3], p[2:0]);
    endfunction

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], feedback};
    endfunction

    function automatic logic [6:0] digitSegments(input int value);
        logic [6:0] lit;
        for (int s = 0; s < 7; s++)
            lit[s] = SegMask[s][value];
        return ~lit;
    endfunction

    function automatic logic isOpposite(input heading_t a, input heading_t b);
        return (a == headUp && b == headDown) || (a == headDown && b == headUp) ||
               (a == headLeft && b == headRight) || (a == headRight && b == headLeft);
    endfunction

    task automatic pushSquare(input int x0, input int y0, input int size, input colour_t c);
        for (int r = 0; r < size; r++)
            for (int col = 0; col < size; col++)
                expectedPixels.push_back({xCoord_t'(x0 + col), yCoord_t'(y0 + r), c});
    endtask

    task automatic pushSnake(input colour_t c);
        for (int i = 0; i < MaxLength; i++)
            pushSquare(modelX[i], modelY[i], SegSize, c);
    endtask

    // active-low keys with right, down, up and left in falling priority
    task automatic pressKeys(input logic [3:0] keys);
        heading_t wanted;
        logic anyKey;
        anyKey = 1'b1;
        wanted = modelHeading;
        if (!keys[0])
            wanted = headRight;
        else if (!keys[1])
            wanted = headDown;
        else if (!keys[2])
            wanted = headUp;
        else if (!keys[3])
            wanted = headLeft;
        else
            anyKey = 1'b0;
        keyN = keys;
        if (anyKey && !isOpposite(wanted, modelHeading))
            modelHeading = wanted;
    endtask

    // queue up one frame of writes and advance the model
    task automatic modelFrame();
        int nextX;
        int nextY;
        logic hit;
        pushSnake(BackgroundColour);
        nextX = modelX[0];
        nextY = modelY[0];
        case (modelHeading)
            headUp:   nextY = nextY - SegSize;
            headDown: nextY = nextY + SegSize;
            headLeft: nextX = nextX - SegSize;
            default:  nextX = nextX + SegSize;
        endcase
        hit = (nextX < 0) || (nextY < 0) || (nextX + SegSize > ScreenWidth) ||
              (nextY + SegSize > ScreenHeight);
        for (int i = 1; i <= MaxLength - 2; i++)
            if (modelX[i] == nextX && modelY[i] == nextY)
                hit = 1'b1;
        if (hit)
        begin
            modelCrashed = 1'b1;
            pushSquare(modelX[0], modelY[0], SegSize, GameOverColour);
        end
        else
        begin
            for (int i = MaxLength - 1; i > 0; i--)
            begin
                modelX[i] = modelX[i - 1];
                modelY[i] = modelY[i - 1];
            end
            modelX[0] = nextX;
            modelY[0] = nextY;
            if (nextX < AppleX[modelAppleIdx] + AppleSize &&
                nextX + SegSize > AppleX[modelAppleIdx] &&
                nextY < AppleY[modelAppleIdx] + AppleSize &&
                nextY + SegSize > AppleY[modelAppleIdx])
            begin
                modelAppleIdx = (modelAppleIdx + 1) % AppleCount;
                if (modelScore < 9)
                    modelScore = modelScore + 1;
            end
            pushSquare(AppleX[modelAppleIdx], AppleY[modelAppleIdx], AppleSize, AppleColour);
            pushSnake(SnakeColour);
        end
    endtask

    task automatic waitDrained();
        while (expectedPixels.size() != 0)
            @(negedge Clock);
    endtask

    task automatic checkScore();
        assert (scoreDigit === digitSegments(modelScore))
        else reportValue(testName, $sformatf("%b", digitSegments(modelScore)),
                         $sformatf("%b", scoreDigit));
    endtask

    task automatic runFrame();
        modelFrame();
        waitDrained();
        checkScore();
    endtask

    // write checker and credit return
    always @(negedge Clock)
    begin
        if (reset)
        begin
            assert (pixelValid === 1'b0)
            else reportValue("reset", "pixelValid 0", $sformatf("pixelValid %b", pixelValid));
        end
        else
        begin
            if (pixelValid === 1'b1)
            begin
                outstanding = outstanding + 1;
                assert (outstanding <= CreditDepth)
                else reportValue("credit limit", $sformatf("at most %0d", CreditDepth),
                                 $sformatf("%0d", outstanding));
                assert (expectedPixels.size() > 0)
                else failWithMessage($sformatf("unexpected write during %s", testName));
                expectedPixel = expectedPixels.pop_front();
                lastWrite = {pixelX, pixelY, pixelColour};
                assert ({pixelX, pixelY, pixelColour} === expectedPixel)
                else reportValue(testName, describePixel(expectedPixel),
                                 describePixel({pixelX, pixelY, pixelColour}));
            end
            else
            begin
                assert (pixelValid === 1'b0)
                else failWithMessage("pixelValid is unknown");
            end
            creditReturn = 1'b0;
            if (outstanding > 0)
            begin
                lfsrState = lfsrNext(lfsrState);
                if (lfsrState[0])
                begin
                    creditReturn = 1'b1;
                    outstanding = outstanding - 1;
                end
            end
        end
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge Clock);
        failWithMessage("watchdog expired before the game finished");
    end

    initial
    begin
        int frames;
        reset = 1'b1;
        keyN = 4'b1111;
        snakeColour = SnakeColour;
        creditReturn = 1'b0;
        for (int i = 0; i < MaxLength; i++)
        begin
            modelX[i] = StartX;
            modelY[i] = StartY + i * SegSize;
        end
        modelHeading = headUp;
        modelAppleIdx = 0;
        modelScore = 0;
        modelCrashed = 1'b0;
        repeat (3) @(posedge Clock);
        @(negedge Clock);

        testName = "initial picture";
        pushSquare(AppleX[0], AppleY[0], AppleSize, AppleColour);
        pushSnake(SnakeColour);
        reset = 1'b0;
        waitDrained();
        // quiet until a key is seen
        repeat (FrameCycles + 100) @(negedge Clock);
        checkScore();

        testName = "movement";
        pressKeys(4'b1011);
        repeat (3) runFrame();
        pressKeys(4'b0111);
        runFrame();

        // right while heading left is a reversal
        testName = "reverse key";
        modelFrame();
        pressKeys(4'b1110);
        repeat (20) @(negedge Clock);
        pressKeys(4'b0111);
        waitDrained();
        checkScore();

        testName = "eating";
        repeat (3) runFrame();
        // one apple eaten
        assert (scoreDigit === digitSegments(1))
        else reportValue(testName, $sformatf("%b", digitSegments(1)),
                         $sformatf("%b", scoreDigit));

        testName = "game over";
        frames = 0;
        while (!modelCrashed && frames < 8)
        begin
            runFrame();
            frames = frames + 1;
        end
        // head ends at (0,30) after up 3 and left 8, marker ends at (9,39)
        assert (lastWrite === {8'd9, 7'd39, GameOverColour})
        else reportValue(testName, describePixel({8'd9, 7'd39, GameOverColour}),
                         describePixel(lastWrite));
        repeat (2 * FrameCycles) @(negedge Clock);
        checkScore();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: snakeGame.f
src/snakeGamePkg.sv
src/moveControl.sv
src/snakeBody.sv
src/appleTracker.sv
src/scoreSegments.sv
src/rectScanner.sv
src/drawSequencer.sv
src/snakeGame.sv
tests/snakeGameTb.sv
